//--- rv_int_pipe.f
+incdir+verification
src/rv_core_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_int_pipe.sv
verification/rv_int_pipe_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the rv_int_pipe testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f rv_int_pipe.f \
  --top-module rv_int_pipe_tb \
  -Mdir obj_dir

status=0
./obj_dir/Vrv_int_pipe_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
fi
echo "Simulation did not pass, exit status $status"
exit 1

//--- verification/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Architectural register state, x0 kept at zero
logic [XLEN-1:0] model_regs [32];

// Uniform pick in 0..n-1 from the seeded stream
function automatic int unsigned rand_below(input int unsigned n);
  return $unsigned($random(seed)) % n;
endfunction

// Integer ops shared by OP and OP-IMM, alt selects SUB or SRA
function automatic logic [XLEN-1:0] int_op(input logic [2:0] f3, input logic alt,
                                           input logic [XLEN-1:0] a,
                                           input logic [XLEN-1:0] b);
  logic [4:0] sh;
  sh = b[4:0];
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << sh;
    // Signed compare by flipping the sign bits
    3'd2: return XLEN'({~a[XLEN-1], a[XLEN-2:0]} < {~b[XLEN-1], b[XLEN-2:0]});
    3'd3: return XLEN'(a < b);
    3'd4: return a ^ b;
    // Arithmetic shift refills the vacated top bits with the sign
    3'd5: return alt ? ((a >> sh) | ({XLEN{a[XLEN-1]}} & ~({XLEN{1'b1}} >> sh))) : a >> sh;
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// Apply one instruction to the model, return the retire it should cause
function automatic wb_t ref_exec(input logic [31:0] word);
  logic [6:0]      opc;
  logic [2:0]      f3;
  logic [6:0]      f7;
  reg_idx_t        rd;
  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic            legal;
  logic            alt;
  logic [XLEN-1:0] value;
  wb_t             res;
  opc   = word[6:0];
  f3    = word[14:12];
  f7    = word[31:25];
  rd    = word[11:7];
  a     = model_regs[word[19:15]];
  b     = model_regs[word[24:20]];
  res   = '0;
  legal = 1'b0;
  alt   = 1'b0;
  value = '0;
  case (opc)
    7'b0110011:
    begin
      // Register form, only ADD/SUB and SRL/SRA have an alt encoding
      legal = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
      alt   = f7[5];
      value = int_op(f3, alt, a, b);
    end
    7'b0010011:
    begin
      // Sign-extended I-immediate
      b = {{(XLEN-12){word[31]}}, word[31:20]};
      if (f3 == 3'd1)
        legal = (f7 == 7'h00);
      else if (f3 == 3'd5)
        legal = (f7 == 7'h00) || (f7 == 7'h20);
      else
        legal = 1'b1;
      alt   = (f3 == 3'd5) && f7[5];
      value = int_op(f3, alt, a, b);
    end
    7'b0110111:
    begin
      legal = 1'b1;
      value = {word[31:12], 12'h000};
    end
    default: legal = 1'b0;
  endcase
  // Illegal or rd=x0 leaves no trace
  if (legal && (rd != '0))
  begin
    model_regs[rd] = value;
    res.valid      = 1'b1;
    res.dst        = rd;
    res.data       = value;
  end
  return res;
endfunction

// Random instruction on x0..x7, some unsupported and some with rd=x0
function automatic logic [31:0] rand_instr();
  int unsigned pick;
  int unsigned form;
  logic [31:0] bits;
  logic [11:0] imm12;
  logic [2:0]  f3;
  logic [6:0]  f7;
  reg_idx_t    rd;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  logic [31:0] word;
  pick  = rand_below(100);
  form  = rand_below(21);
  bits  = $random(seed);
  imm12 = bits[11:0];
  rs1   = reg_idx_t'(rand_below(8));
  rs2   = reg_idx_t'(rand_below(8));
  if ((pick >= 10) && (pick < 20))
    rd = '0;
  else
    rd = reg_idx_t'(rand_below(7) + 1);
  if (form < 8)
  begin
    // OP with base funct7
    f3   = 3'(form);
    word = {7'h00, rs2, rs1, f3, rd, 7'b0110011};
  end
  else if (form < 10)
  begin
    // SUB or SRA
    f3   = (form == 8) ? 3'd0 : 3'd5;
    word = {7'h20, rs2, rs1, f3, rd, 7'b0110011};
  end
  else if (form < 19)
  begin
    // OP-IMM, form 18 is SRAI
    f3 = (form == 18) ? 3'd5 : 3'(form - 10);
    f7 = (form == 18) ? 7'h20 : 7'h00;
    if ((f3 == 3'd1) || (f3 == 3'd5))
      imm12 = {f7, bits[4:0]};
    word = {imm12, rs1, f3, rd, 7'b0010011};
  end
  else
    word = {bits[31:12], rd, 7'b0110111};
  if (pick < 10)
  begin
    // Load, MUL and SLLI with a bad funct7
    case (rand_below(3))
      0:       word = {bits[31:20], rs1, 3'b010, rd, 7'b0000011};
      1:       word = {7'h01, rs2, rs1, 3'b000, rd, 7'b0110011};
      default: word = {7'h20, bits[4:0], rs1, 3'b001, rd, 7'b0010011};
    endcase
  end
  return word;
endfunction

`endif

//--- verification/rv_int_pipe_tb.sv
`timescale 1ns/1ns

module rv_int_pipe_tb
  import rv_core_pkg::*;
();

  //////////////////////////////
  // Run limits
  //////////////////////////////

  localparam int CLK_HALF      = 10;
  localparam int RESET_CYCLES  = 4;
  localparam int PROG_LEN      = 300;
  localparam int DRAIN_CYCLES  = 6;
  localparam int QUEUE_TIMEOUT = 50;
  localparam int MAX_CYCLES    = 10000;

  logic                 clk_i;
  logic                 rst_i;
  logic                 stall_i;
  logic [31:0]          instr_i;
  logic                 instr_valid_i;
  logic                 du_re_i;
  logic                 du_we_i;
  logic [DU_ADDR_W-1:0] du_addr_i;
  logic [XLEN-1:0]      du_d_i;
  logic [XLEN-1:0]      du_q_o;
  wb_t                  retire_o;

  integer seed = 32'hdbd5;
  // Expected retires in program order
  wb_t    exp_q [$];
  wb_t    exp_head;

  `include "rv_ref_model.svh"

  rv_int_pipe dut0 (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .stall_i       (stall_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .du_re_i       (du_re_i),
    .du_we_i       (du_we_i),
    .du_addr_i     (du_addr_i),
    .du_d_i        (du_d_i),
    .du_q_o        (du_q_o),
    .retire_o      (retire_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  //////////////////////////////
  // Failure and check
  //////////////////////////////

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] want);
    if (got !== want)
      fail_run($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, want));
  endtask

  //////////////////////////////
  // Debug port access
  //////////////////////////////

  // Write lands on the second edge
  task automatic debug_write(input reg_idx_t idx, input logic [XLEN-1:0] value);
    @(posedge clk_i);
    du_we_i   <= 1'b1;
    du_addr_i <= DU_ADDR_W'(idx);
    du_d_i    <= value;
    @(posedge clk_i);
    du_we_i   <= 1'b0;
  endtask

  task automatic debug_read(input reg_idx_t idx, output logic [XLEN-1:0] value);
    @(posedge clk_i);
    du_re_i   <= 1'b1;
    du_addr_i <= DU_ADDR_W'(idx);
    // Address captured here
    @(posedge clk_i);
    du_re_i   <= 1'b0;
    // Data loaded into du_q_o here
    @(posedge clk_i);
    @(negedge clk_i);
    value = du_q_o;
  endtask

  //////////////////////////////
  // Program driver
  //////////////////////////////

  // One instruction per unstalled cycle
  // Model updated in program order
  task automatic run_program(input int unsigned count, input int unsigned stall_pct);
    int unsigned sent;
    int unsigned cycles;
    logic        stall_now;
    logic [31:0] word;
    wb_t         expect_wb;
    sent   = 0;
    cycles = 0;
    while ((sent < count) && (cycles < count * 20))
    begin
      @(posedge clk_i);
      cycles++;
      stall_now = (rand_below(100) < stall_pct);
      stall_i <= stall_now;
      if (stall_now)
        instr_valid_i <= 1'b0;
      else
      begin
        word = rand_instr();
        instr_i       <= word;
        instr_valid_i <= 1'b1;
        expect_wb = ref_exec(word);
        if (expect_wb.valid)
          exp_q.push_back(expect_wb);
        sent++;
      end
    end
    if (sent < count)
      fail_run("Program did not finish sending within its cycle limit");
    // Last instruction accepted on this edge
    @(posedge clk_i);
    instr_valid_i <= 1'b0;
    stall_i       <= 1'b0;
  endtask

  // Bubbles until wb is empty and the last write has landed
  task automatic drain_pipe();
    int n;
    for (n = 0; n < DRAIN_CYCLES; n++)
    begin
      @(posedge clk_i);
      stall_i       <= 1'b0;
      instr_valid_i <= 1'b0;
    end
  endtask

  task automatic wait_queue_empty();
    int cycles;
    cycles = 0;
    while ((exp_q.size() != 0) && (cycles < QUEUE_TIMEOUT))
    begin
      @(posedge clk_i);
      cycles++;
    end
    if (exp_q.size() != 0)
      fail_run("Timed out waiting for all expected retires to arrive");
  endtask

  //////////////////////////////
  // Compare process
  //////////////////////////////

  // A retire counts once on the edge that consumes it
  always @(negedge clk_i)
  begin
    if (!rst_i && !stall_i && retire_o.valid)
    begin
      if (exp_q.size() == 0)
        fail_run("A retire arrived with no expected result in the queue");
      else
      begin
        exp_head = exp_q.pop_front();
        check_value("retire_o.dst", XLEN'(retire_o.dst), XLEN'(exp_head.dst));
        check_value("retire_o.data", retire_o.data, exp_head.data);
      end
    end
  end

  // Watchdog
  initial
  begin : watchdog
    int cycles;
    for (cycles = 0; cycles < MAX_CYCLES; cycles++)
      @(posedge clk_i);
    fail_run("Simulation hit its cycle limit without finishing");
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial
  begin : stimulus
    logic [XLEN-1:0] got;
    logic [XLEN-1:0] value;
    reg_idx_t        idx;
    int              n;
    rst_i         = 1'b1;
    stall_i       = 1'b0;
    instr_i       = '0;
    instr_valid_i = 1'b0;
    du_re_i       = 1'b0;
    du_we_i       = 1'b0;
    du_addr_i     = '0;
    du_d_i        = '0;
    for (n = 0; n < 32; n++)
    begin
      idx = reg_idx_t'(n);
      model_regs[idx] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;

    // Nothing retires while idle after reset
    for (n = 0; n < 8; n++)
    begin
      @(negedge clk_i);
      check_value("retire_o.valid", XLEN'(retire_o.valid), '0);
    end

    // Seed every register over the debug port including x0
    @(posedge clk_i);
    stall_i <= 1'b1;
    for (n = 0; n < 32; n++)
    begin
      idx   = reg_idx_t'(n);
      value = $random(seed);
      debug_write(idx, value);
      if (idx != '0)
        model_regs[idx] = value;
    end
    debug_read('0, got);
    check_value("du_q_o x0", got, '0);
    for (n = 0; n < 6; n++)
    begin
      idx = reg_idx_t'(rand_below(31) + 1);
      debug_read(idx, got);
      check_value($sformatf("du_q_o x%0d", idx), got, model_regs[idx]);
    end

    // Back to back first and then with random stalls
    run_program(PROG_LEN, 0);
    drain_pipe();
    run_program(PROG_LEN, 30);
    drain_pipe();

    // Final register state
    wait_queue_empty();
    @(posedge clk_i);
    stall_i <= 1'b1;
    for (n = 0; n < 32; n++)
    begin
      idx = reg_idx_t'(n);
      debug_read(idx, got);
      check_value($sformatf("du_q_o x%0d", idx), got, model_regs[idx]);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- src/rv_int_pipe.sv
`timescale 1ns/1ns

module rv_int_pipe
  import rv_core_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 stall_i,
  input  logic [31:0]          instr_i,
  input  logic                 instr_valid_i,
  input  logic                 du_re_i,
  input  logic                 du_we_i,
  input  logic [DU_ADDR_W-1:0] du_addr_i,
  input  logic [XLEN-1:0]      du_d_i,
  output logic [XLEN-1:0]      du_q_o,
  output wb_t                  retire_o
);

  reg_idx_t        src1;
  reg_idx_t        src2;
  dec_op_t         ex_op;
  logic [XLEN-1:0] operand1;
  logic [XLEN-1:0] operand2;
  wb_t             wb;

  //////////////////////////////
  // Decode, regfile, execute
  //////////////////////////////

  rv_decode u_decode (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .stall_i       (stall_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .src1_o        (src1),
    .src2_o        (src2),
    .ex_op_o       (ex_op)
  );

  // Write port fed straight from the writeback register
  rv_regfile u_regfile (
    .clk_i      (clk_i),
    .stall_i    (stall_i),
    .src1_i     (src1),
    .src2_i     (src2),
    .operand1_o (operand1),
    .operand2_o (operand2),
    .wb_i       (wb),
    .we_i       (wb.valid),
    .du_re_i    (du_re_i),
    .du_we_i    (du_we_i),
    .du_addr_i  (du_addr_i),
    .du_d_i     (du_d_i),
    .du_q_o     (du_q_o)
  );

  rv_alu u_alu (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .stall_i    (stall_i),
    .ex_op_i    (ex_op),
    .operand1_i (operand1),
    .operand2_i (operand2),
    .wb_o       (wb)
  );

  assign retire_o = wb;

endmodule

//--- src/rv_alu.sv
`timescale 1ns/1ns

module rv_alu
  import rv_core_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            stall_i,
  input  dec_op_t         ex_op_i,
  input  logic [XLEN-1:0] operand1_i,
  input  logic [XLEN-1:0] operand2_i,
  output wb_t             wb_o
);

  logic            fwd1;
  logic            fwd2;
  logic [XLEN-1:0] opa;
  logic [XLEN-1:0] opb_reg;
  logic [XLEN-1:0] opb;
  logic [4:0]      shamt;
  logic [XLEN-1:0] result;

  //////////////////////////////
  // Operand select
  //////////////////////////////

  // Previous result still sits in wb_o, x0 never matches
  assign fwd1 = wb_o.valid && (ex_op_i.src1 != '0) && (wb_o.dst == ex_op_i.src1);
  assign fwd2 = wb_o.valid && (ex_op_i.src2 != '0) && (wb_o.dst == ex_op_i.src2);

  assign opa     = fwd1 ? wb_o.data : operand1_i;
  assign opb_reg = fwd2 ? wb_o.data : operand2_i;
  // Immediate forms replace the second operand
  assign opb     = ex_op_i.use_imm ? ex_op_i.imm : opb_reg;
  assign shamt   = opb[4:0];

  //////////////////////////////
  // Compute
  //////////////////////////////

  always_comb
  begin
    case (ex_op_i.op)
      ALU_ADD:  result = opa + opb;
      ALU_SUB:  result = opa - opb;
      ALU_SLL:  result = opa << shamt;
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, opa < opb};
      ALU_XOR:  result = opa ^ opb;
      ALU_SRL:  result = opa >> shamt;
      ALU_SRA:  result = $unsigned($signed(opa) >>> shamt);
      ALU_OR:   result = opa | opb;
      ALU_AND:  result = opa & opb;
      // Upper immediate is already shifted by decode
      ALU_LUI:  result = opb;
      default:  result = '0;
    endcase
  end

  // Writeback register, doubles as the retire output
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      wb_o.valid <= 1'b0;
    else if (!stall_i)
    begin
      wb_o.valid <= ex_op_i.valid;
      wb_o.dst   <= ex_op_i.dst;
      wb_o.data  <= result;
    end
  end

  // Decode drops rd=x0, so nothing retires to x0
  a_wb_dst_nonzero : assert property (@(posedge clk_i) disable iff (rst_i)
    wb_o.valid |-> (wb_o.dst != '0));

endmodule

//--- src/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile
  import rv_core_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 stall_i,
  input  reg_idx_t             src1_i,
  input  reg_idx_t             src2_i,
  output logic [XLEN-1:0]      operand1_o,
  output logic [XLEN-1:0]      operand2_o,
  input  wb_t                  wb_i,
  input  logic                 we_i,
  input  logic                 du_re_i,
  input  logic                 du_we_i,
  input  logic [DU_ADDR_W-1:0] du_addr_i,
  input  logic [XLEN-1:0]      du_d_i,
  output logic [XLEN-1:0]      du_q_o
);

  // Register array, x0 entry exists but is masked on read
  logic [XLEN-1:0] rf_mem [32];

  // Registered read addresses
  reg_idx_t        src1_q;
  reg_idx_t        src2_q;
  logic            src1_is_x0;
  logic            src2_is_x0;
  logic [XLEN-1:0] rfout1;
  logic [XLEN-1:0] rfout2;
  logic [XLEN-1:0] dout1;
  logic [XLEN-1:0] dout2;
  logic            wr_en;
  logic            du_re_dly;

  //////////////////////////////
  // Read address port
  //////////////////////////////

  // Debug read takes over port 1
  always_ff @(posedge clk_i)
  begin
    if (du_re_i)
      src1_q <= reg_idx_t'(du_addr_i[REG_IDX_W-1:0]);
    else if (!stall_i)
      src1_q <= src1_i;
    if (!stall_i)
    begin
      src2_q     <= src2_i;
      src1_is_x0 <= (src1_i == '0);
      src2_is_x0 <= (src2_i == '0);
    end
  end

  assign rfout1 = rf_mem[src1_q];
  assign rfout2 = rf_mem[src2_q];

  // Pipeline write only on an advancing edge
  assign wr_en = we_i && !stall_i;

  // x0 first, then same-cycle write bypass, then array
  always_comb
  begin
    if (src1_is_x0)
      dout1 = '0;
    else if (wr_en && (wb_i.dst == src1_q))
      dout1 = wb_i.data;
    else
      dout1 = rfout1;
    if (src2_is_x0)
      dout2 = '0;
    else if (wr_en && (wb_i.dst == src2_q))
      dout2 = wb_i.data;
    else
      dout2 = rfout2;
  end

  // Operand registers feeding execute
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      operand1_o <= dout1;
      operand2_o <= dout2;
    end
  end

  //////////////////////////////
  // Debug and write port
  //////////////////////////////

  // Address lands in src1_q first, data one cycle later
  always_ff @(posedge clk_i)
    du_re_dly <= du_re_i;

  always_ff @(posedge clk_i)
  begin
    if (du_re_dly)
      du_q_o <= (src1_q == '0) ? '0 : rfout1;
  end

  // Debug write wins over the pipeline
  always_ff @(posedge clk_i)
  begin
    if (du_we_i)
      rf_mem[du_addr_i[REG_IDX_W-1:0]] <= du_d_i;
    else if (wr_en)
      rf_mem[wb_i.dst] <= wb_i.data;
  end

  // Debug access only with the pipeline frozen
  a_du_stalled : assert property (@(posedge clk_i)
    (du_re_i || du_we_i) |-> stall_i);
  // One debug access at a time
  a_du_onehot : assert property (@(posedge clk_i)
    !(du_re_i && du_we_i));

endmodule

//--- src/rv_decode.sv
`timescale 1ns/1ns

module rv_decode
  import rv_core_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        stall_i,
  input  logic [31:0] instr_i,
  input  logic        instr_valid_i,
  output reg_idx_t    src1_o,
  output reg_idx_t    src2_o,
  output dec_op_t     ex_op_o
);

  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic        supported;
  reg_idx_t    src1;
  reg_idx_t    src2;
  dec_op_t     dec_d;
  // Decode stage and execute stage registers
  dec_op_t     dec_q;
  dec_op_t     ex_q;

  //////////////////////////////
  // Field extraction
  //////////////////////////////

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb
  begin
    dec_d     = '0;
    supported = 1'b1;
    src1      = instr_i[19:15];
    src2      = instr_i[24:20];
    dec_d.dst = instr_i[11:7];
    case (opcode)
      OPC_OP_IMM:
      begin
        // I-immediate, rs2 field is part of the immediate
        dec_d.use_imm = 1'b1;
        dec_d.imm     = {{20{instr_i[31]}}, instr_i[31:20]};
        src2          = '0;
        case (funct3)
          3'b000: dec_d.op = ALU_ADD;
          3'b010: dec_d.op = ALU_SLT;
          3'b011: dec_d.op = ALU_SLTU;
          3'b100: dec_d.op = ALU_XOR;
          3'b110: dec_d.op = ALU_OR;
          3'b111: dec_d.op = ALU_AND;
          3'b001:
          begin
            dec_d.op  = ALU_SLL;
            supported = (funct7 == F7_BASE);
          end
          default:
          begin
            // Shift right, funct7 picks logical or arithmetic
            dec_d.op  = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            supported = (funct7 == F7_BASE) || (funct7 == F7_ALT);
          end
        endcase
      end
      OPC_OP:
      begin
        case ({funct7, funct3})
          {F7_BASE, 3'b000}: dec_d.op = ALU_ADD;
          {F7_ALT,  3'b000}: dec_d.op = ALU_SUB;
          {F7_BASE, 3'b001}: dec_d.op = ALU_SLL;
          {F7_BASE, 3'b010}: dec_d.op = ALU_SLT;
          {F7_BASE, 3'b011}: dec_d.op = ALU_SLTU;
          {F7_BASE, 3'b100}: dec_d.op = ALU_XOR;
          {F7_BASE, 3'b101}: dec_d.op = ALU_SRL;
          {F7_ALT,  3'b101}: dec_d.op = ALU_SRA;
          {F7_BASE, 3'b110}: dec_d.op = ALU_OR;
          {F7_BASE, 3'b111}: dec_d.op = ALU_AND;
          default:           supported = 1'b0;
        endcase
      end
      OPC_LUI:
      begin
        // U-immediate, no register sources
        dec_d.op      = ALU_LUI;
        dec_d.use_imm = 1'b1;
        dec_d.imm     = {instr_i[31:12], 12'b0};
        src1          = '0;
        src2          = '0;
      end
      default: supported = 1'b0;
    endcase
    dec_d.src1  = src1;
    dec_d.src2  = src2;
    // Unsupported or rd=x0 becomes a bubble
    dec_d.valid = instr_valid_i && supported && (dec_d.dst != '0);
  end

  // Sources go straight to the register file address port
  assign src1_o = src1;
  assign src2_o = src2;

  //////////////////////////////
  // Op pipe, two entries
  //////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      dec_q.valid <= 1'b0;
      ex_q.valid  <= 1'b0;
    end
    else if (!stall_i)
    begin
      dec_q <= dec_d;
      ex_q  <= dec_q;
    end
  end

  assign ex_op_o = ex_q;

  // A valid op reaching execute is always fully defined
  a_ex_op_known : assert property (@(posedge clk_i) disable iff (rst_i)
    ex_op_o.valid |-> !$isunknown(ex_op_o.op));

endmodule

//--- src/rv_core_pkg.sv
package rv_core_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Integer register width
  localparam int XLEN      = 32;
  // Register index width, 32 registers
  localparam int REG_IDX_W = 5;
  // Debug address bus, only low bits select a register
  localparam int DU_ADDR_W = 12;

  // funct7 variants used by OP and shift-immediate encodings
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI
  } alu_op_e;

  // Major opcodes handled by decode
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  // Decoded op, travels from decode to execute
  typedef struct packed {
    logic            valid;
    alu_op_e         op;
    reg_idx_t        dst;
    reg_idx_t        src1;
    reg_idx_t        src2;
    logic            use_imm;
    logic [XLEN-1:0] imm;
  } dec_op_t;

  // Writeback / retire record
  typedef struct packed {
    logic            valid;
    reg_idx_t        dst;
    logic [XLEN-1:0] data;
  } wb_t;

endpackage
